//--- apbDataRam.sv
`timescale 1ns/1ps
`default_nettype none

module apbDataRam #(
    parameter int RAM_WORDS   = memBusPkg::DEFAULT_RAM_WORDS,
    parameter int WAIT_STATES = memBusPkg::DEFAULT_WAIT_STATES
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire memBusPkg::ApbAddr  paddr,
    input  wire memBusPkg::ApbData  pwdata,
    input  wire memBusPkg::ApbStrb  pstrb,
    output memBusPkg::ApbData       prdata,
    output logic                    pready
);
    import memBusPkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int CNT_W = $clog2(WAIT_STATES + 2);

    ApbData           mem [RAM_WORDS];
    logic [IDX_W-1:0] wordIdx;
    logic [CNT_W-1:0] waitCnt;
    logic             access;

    assign wordIdx = paddr[IDX_W+1:2];
    assign access  = psel && penable;

    ////////////////////////////////////////////////////////////
    // Wait states
    ////////////////////////////////////////////////////////////
    assign pready = access && (waitCnt == CNT_W'(WAIT_STATES));

    always_ff @(posedge clk) begin
        if (rst) begin
            waitCnt <= '0;
        end else if (!access || pready) begin
            waitCnt <= '0;
        end else begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // Strobed write on the completing cycle
    always_ff @(posedge clk) begin
        if (pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[wordIdx][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data is sampled from setup onward so it is ready with pready
    always_ff @(posedge clk) begin
        if (psel && !pwrite) begin
            prdata <= mem[wordIdx];
        end
    end

    enableInsideSelect : assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

endmodule

`default_nettype wire

//--- files.f
lsuOpsPkg.sv
memBusPkg.sv
uopQueue.sv
loadStoreUnit.sv
apbDataRam.sv
lsuTop.sv
tbLsu.sv

//--- loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     fireStore,
    input  wire                     headValid,
    input  wire lsuOpsPkg::LsuOp    headOp,
    input  wire lsuOpsPkg::Word     headBase,
    input  wire lsuOpsPkg::Imm16    headImm,
    input  wire lsuOpsPkg::Word     headStoreData,
    input  wire lsuOpsPkg::PhysReg  headDst,
    input  wire lsuOpsPkg::RobTag   headTag,
    output logic                    pop,
    output logic                    busy,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output memBusPkg::ApbAddr       paddr,
    output memBusPkg::ApbData       pwdata,
    output memBusPkg::ApbStrb       pstrb,
    input  wire memBusPkg::ApbData  prdata,
    input  wire                     pready,
    output logic                    wbValid,
    output lsuOpsPkg::PhysReg       wbDst,
    output lsuOpsPkg::Word          wbData,
    output lsuOpsPkg::RobTag        wbTag,
    output logic                    storeReady,
    output lsuOpsPkg::RobTag        storeTag
);
    import lsuOpsPkg::*;

    typedef enum logic [2:0] {
        Idle,
        LoadSetup,
        LoadAccess,
        StoreWait,
        StoreSetup,
        StoreAccess,
        Drain
    } LsuState;

    LsuState     state;
    LsuState     nextState;

    // Current uop
    LsuOp        opReg;
    Word         addrReg;
    Word         storeDataReg;
    PhysReg      dstReg;
    RobTag       tagReg;

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    Word         loadValue;

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                // Nop uops are popped and dropped here
                if (headValid && !flush) begin
                    if (isLoad(headOp)) begin
                        nextState = LoadSetup;
                    end else if (isStore(headOp)) begin
                        nextState = StoreWait;
                    end
                end
            end
            LoadSetup: begin
                nextState = flush ? Drain : LoadAccess;
            end
            LoadAccess: begin
                if (pready) begin
                    nextState = Idle;
                end else if (flush) begin
                    nextState = Drain;
                end
            end
            StoreWait: begin
                if (flush) begin
                    nextState = Idle;
                end else if (fireStore) begin
                    nextState = StoreSetup;
                end
            end
            StoreSetup: begin
                nextState = flush ? Drain : StoreAccess;
            end
            StoreAccess: begin
                if (pready) begin
                    nextState = Idle;
                end else if (flush) begin
                    nextState = Drain;
                end
            end
            Drain: begin
                // Unabortable transfer finishes quietly
                if (pready) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    assign pop  = (state == Idle) && headValid && !flush;
    assign busy = (state != Idle);

    // Capture head and form the effective address
    always_ff @(posedge clk) begin
        if (pop) begin
            opReg        <= headOp;
            addrReg      <= headBase + {{16{headImm[15]}}, headImm};
            storeDataReg <= headStoreData;
            dstReg       <= headDst;
            tagReg       <= headTag;
        end
    end

    ////////////////////////////////////////////////////////////
    // APB requester outputs
    ////////////////////////////////////////////////////////////
    assign psel    = (state == LoadSetup) || (state == LoadAccess) || (state == StoreSetup)
                  || (state == StoreAccess) || (state == Drain);
    assign penable = (state == LoadAccess) || (state == StoreAccess) || (state == Drain);
    assign pwrite  = psel && isStore(opReg);
    assign paddr   = {addrReg[31:2], 2'b00};

    // Store data moved into its byte lane
    assign pwdata  = storeDataReg << {addrReg[1:0], 3'b000};

    always_comb begin
        pstrb = '0;
        if (pwrite) begin
            case (opReg)
                OpSb:    pstrb = 4'b0001 << addrReg[1:0];
                OpSh:    pstrb = addrReg[1] ? 4'b1100 : 4'b0011;
                OpSw:    pstrb = 4'b1111;
                default: pstrb = '0;
            endcase
        end
    end

    // Load lane select and extension
    always_comb begin
        loadByte = prdata[{addrReg[1:0], 3'b000} +: 8];
        loadHalf = addrReg[1] ? prdata[31:16] : prdata[15:0];
        case (opReg)
            OpLb:    loadValue = {{24{loadByte[7]}}, loadByte};
            OpLbu:   loadValue = {24'b0, loadByte};
            OpLh:    loadValue = {{16{loadHalf[15]}}, loadHalf};
            OpLhu:   loadValue = {16'b0, loadHalf};
            default: loadValue = prdata;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write-back and commit handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid    <= 1'b0;
            storeReady <= 1'b0;
        end else begin
            wbValid    <= (state == LoadAccess) && pready && !flush;
            storeReady <= pop && isStore(headOp);
        end
    end

    always_ff @(posedge clk) begin
        if ((state == LoadAccess) && pready) begin
            wbData <= loadValue;
            wbDst  <= dstReg;
            wbTag  <= tagReg;
        end
    end

    assign storeTag = tagReg;

    // Misaligned accesses are not supported
    alignedAccess : assert property (@(posedge clk) disable iff (rst)
        psel |-> !((opReg inside {OpLh, OpLhu, OpSh}) && addrReg[0])
              && !((opReg inside {OpLw, OpSw}) && (addrReg[1:0] != 2'b00)));

    // Requester holds the transfer until the RAM completes it
    requestHeld : assert property (@(posedge clk) disable iff (rst)
        psel && !pready |=> psel && $stable({paddr, pwrite, pwdata, pstrb}));

endmodule

`default_nettype wire

//--- lsuOpsPkg.sv
`default_nettype none

package lsuOpsPkg;

    ////////////////////////////////////////////////////////////
    // Memory uop codes
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        OpNop = 4'h0,
        OpLb  = 4'h1,
        OpLbu = 4'h2,
        OpLh  = 4'h3,
        OpLhu = 4'h4,
        OpLw  = 4'h5,
        OpSb  = 4'h6,
        OpSh  = 4'h7,
        OpSw  = 4'h8
    } LsuOp;

    typedef logic [5:0]  RobTag;
    typedef logic [5:0]  PhysReg;
    typedef logic [31:0] Word;
    typedef logic [15:0] Imm16;

    // Decode helpers
    function automatic logic isLoad(input LsuOp op);
        return op inside {OpLb, OpLbu, OpLh, OpLhu, OpLw};
    endfunction

    function automatic logic isStore(input LsuOp op);
        return op inside {OpSb, OpSh, OpSw};
    endfunction

endpackage

`default_nettype wire

//--- lsuTests.mem
// kind op base imm data dst tag expected
// kind 1 issue, 2 held store, 3 fire (expected is issueReady), 4 flush, 5 flushed load, 6 end
1 8 00000100 0000 11223344 00 01 00000000
1 8 00000100 0004 A5A55A5A 00 02 00000000
1 8 00000200 FFFC 0BADF00D 00 03 00000000
1 5 00000100 0000 00000000 0A 04 11223344
1 5 00000108 FFFC 00000000 0B 05 A5A55A5A
1 5 000001F0 000C 00000000 0C 06 0BADF00D
6 0 00000000 0000 00000000 00 00 00000001
1 8 00000120 0000 80F17F82 00 07 00000000
1 1 00000120 0000 00000000 01 08 FFFFFF82
1 2 00000121 0000 00000000 02 09 0000007F
1 1 00000122 0000 00000000 03 0A FFFFFFF1
1 2 00000124 FFFF 00000000 04 0B 00000080
1 3 00000120 0000 00000000 05 0C 00007F82
1 4 00000122 0000 00000000 06 0D 000080F1
1 3 00000122 0000 00000000 07 0E FFFF80F1
6 0 00000000 0000 00000000 00 00 00000002
1 8 00000140 0000 11223344 00 0F 00000000
1 6 00000141 0000 000000AB 00 10 00000000
1 7 00000142 0000 0000CDEF 00 11 00000000
1 6 00000140 0000 FFFFFF99 00 12 00000000
1 5 00000140 0000 00000000 08 13 CDEFAB99
6 0 00000000 0000 00000000 00 00 00000003
2 8 00000160 0000 CAFEBABE 00 14 00000000
1 5 00000160 0000 00000000 1F 15 CAFEBABE
3 0 00000000 0000 00000000 00 00 00000001
6 0 00000000 0000 00000000 00 00 00000004
2 8 00000180 0000 5EED0001 00 16 00000000
1 5 00000100 0000 00000000 10 17 11223344
1 5 00000104 0000 00000000 11 18 A5A55A5A
1 5 00000120 0000 00000000 12 19 80F17F82
1 5 00000140 0000 00000000 13 1A CDEFAB99
3 0 00000000 0000 00000000 00 00 00000000
1 5 00000180 0000 00000000 14 1B 5EED0001
6 0 00000000 0000 00000000 00 00 00000005
2 8 00000100 0000 DEADBEEF 00 1C 00000000
5 5 00000100 0000 00000000 15 1D 00000000
5 1 00000120 0000 00000000 16 1E 00000000
4 0 00000000 0000 00000000 00 00 00000000
1 5 00000100 0000 00000000 17 1F 11223344
1 2 00000123 0000 00000000 18 20 00000080
6 0 00000000 0000 00000000 00 00 00000006
0 0 00000000 0000 00000000 00 00 00000000

//--- lsuTop.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTop #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RAM_WORDS   = memBusPkg::DEFAULT_RAM_WORDS,
    parameter int WAIT_STATES = memBusPkg::DEFAULT_WAIT_STATES
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     fireStore,
    // Issue port
    input  wire                     issueValid,
    output logic                    issueReady,
    input  wire lsuOpsPkg::LsuOp    issueOp,
    input  wire lsuOpsPkg::Word     issueBase,
    input  wire lsuOpsPkg::Imm16    issueImm,
    input  wire lsuOpsPkg::Word     issueStoreData,
    input  wire lsuOpsPkg::PhysReg  issueDst,
    input  wire lsuOpsPkg::RobTag   issueTag,
    output logic                    busy,
    // Write-back and commit
    output logic                    wbValid,
    output lsuOpsPkg::PhysReg       wbDst,
    output lsuOpsPkg::Word          wbData,
    output lsuOpsPkg::RobTag        wbTag,
    output logic                    storeReady,
    output lsuOpsPkg::RobTag        storeTag
);
    import lsuOpsPkg::*;
    import memBusPkg::*;

    // Queue head
    logic   headValid;
    LsuOp   headOp;
    Word    headBase;
    Imm16   headImm;
    Word    headStoreData;
    PhysReg headDst;
    RobTag  headTag;
    logic   pop;

    // APB between unit and RAM
    logic   psel;
    logic   penable;
    logic   pwrite;
    ApbAddr paddr;
    ApbData pwdata;
    ApbStrb pstrb;
    ApbData prdata;
    logic   pready;

    ////////////////////////////////////////////////////////////
    // Producer, consumer and memory
    ////////////////////////////////////////////////////////////
    uopQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue0 (
        .clk(clk), .rst(rst), .flush(flush),
        .issueValid(issueValid), .issueReady(issueReady),
        .issueOp(issueOp), .issueBase(issueBase), .issueImm(issueImm),
        .issueStoreData(issueStoreData), .issueDst(issueDst), .issueTag(issueTag),
        .pop(pop), .headValid(headValid), .headOp(headOp), .headBase(headBase),
        .headImm(headImm), .headStoreData(headStoreData), .headDst(headDst),
        .headTag(headTag)
    );

    loadStoreUnit lsu0 (
        .clk(clk), .rst(rst), .flush(flush), .fireStore(fireStore),
        .headValid(headValid), .headOp(headOp), .headBase(headBase), .headImm(headImm),
        .headStoreData(headStoreData), .headDst(headDst), .headTag(headTag),
        .pop(pop), .busy(busy),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .wbTag(wbTag),
        .storeReady(storeReady), .storeTag(storeTag)
    );

    apbDataRam #(
        .RAM_WORDS(RAM_WORDS),
        .WAIT_STATES(WAIT_STATES)
    ) ram0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

endmodule

`default_nettype wire

//--- memBusPkg.sv
`default_nettype none

package memBusPkg;

    ////////////////////////////////////////////////////////////
    // APB data path types
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] ApbAddr;
    typedef logic [31:0] ApbData;
    typedef logic [3:0]  ApbStrb;

    // RAM defaults
    parameter int DEFAULT_RAM_WORDS   = 256;
    // Extra access cycles before pready
    parameter int DEFAULT_WAIT_STATES = 1;

endpackage

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tbLsu -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VtbLsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0

//--- tbLsu.sv
`timescale 1ns/1ps
`default_nettype none

module tbLsu;
    import lsuOpsPkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int WAIT_STATES    = 1;
    localparam int MAX_VECTORS    = 64;
    localparam int VEC_FIELDS     = 8;
    localparam int TIMEOUT_CYCLES = 200;

    // Line kinds in the test file
    localparam logic [3:0] KIND_END   = 4'h0;
    localparam logic [3:0] KIND_ISSUE = 4'h1;
    localparam logic [3:0] KIND_HOLD  = 4'h2;
    localparam logic [3:0] KIND_FIRE  = 4'h3;
    localparam logic [3:0] KIND_FLUSH = 4'h4;
    localparam logic [3:0] KIND_DROP  = 4'h5;
    localparam logic [3:0] KIND_DONE  = 4'h6;

    logic   clk = 1'b0;
    logic   rst;
    logic   flush;
    logic   fireStore;
    logic   issueValid;
    logic   issueReady;
    LsuOp   issueOp;
    Word    issueBase;
    Imm16   issueImm;
    Word    issueStoreData;
    PhysReg issueDst;
    RobTag  issueTag;
    logic   busy;
    logic   wbValid;
    PhysReg wbDst;
    Word    wbData;
    RobTag  wbTag;
    logic   storeReady;
    RobTag  storeTag;

    logic [31:0] vecMem [MAX_VECTORS*VEC_FIELDS];
    // Pending write-backs as {dst, tag, data}, stores as {held, tag}
    logic [43:0] wbExpect[$];
    logic [6:0]  storeExpect[$];

    logic   storeWaiting;
    logic   storeHeld;
    logic   abortRun;
    int     fireGap;
    int     errorCount;
    int     testErrors;
    int     testCount;
    int     checkCount;
    integer seed = 32'h61bc_bcd6;

    always #10 clk = ~clk;

    lsuTop #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RAM_WORDS(256),
        .WAIT_STATES(WAIT_STATES)
    ) dut0 (
        .clk(clk), .rst(rst), .flush(flush), .fireStore(fireStore),
        .issueValid(issueValid), .issueReady(issueReady), .issueOp(issueOp),
        .issueBase(issueBase), .issueImm(issueImm), .issueStoreData(issueStoreData),
        .issueDst(issueDst), .issueTag(issueTag), .busy(busy),
        .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .wbTag(wbTag),
        .storeReady(storeReady), .storeTag(storeTag)
    );

    task automatic noteError(input string what);
        $display("%s", what);
        errorCount++;
        testErrors++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            noteError($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    task automatic reportTimeout(input string what);
        noteError($sformatf("Timeout: %s", what));
        abortRun = 1'b1;
    endtask

    function automatic logic allDrained();
        return (wbExpect.size() == 0) && (storeExpect.size() == 0) && !storeWaiting && !busy;
    endfunction

    ////////////////////////////////////////////////////////////
    // One clock step: sample outputs, play the commit logic
    ////////////////////////////////////////////////////////////
    task automatic advanceCycle();
        logic [43:0] exp;
        logic [6:0]  st;
        @(negedge clk);
        fireStore = 1'b0;
        flush     = 1'b0;
        if (wbValid) begin
            // Loads behind an uncommitted store must stay blocked
            if (storeWaiting) begin
                noteError($sformatf("Load tag 0x%02h wrote back before its store committed",
                                    wbTag));
            end
            if (wbExpect.size() == 0) begin
                noteError($sformatf("Write-back with tag 0x%02h was not expected", wbTag));
            end else begin
                exp = wbExpect.pop_front();
                checkValue("wbDst", 32'(wbDst), 32'(exp[43:38]));
                checkValue("wbTag", 32'(wbTag), 32'(exp[37:32]));
                checkValue("wbData", wbData, exp[31:0]);
            end
        end
        if (storeReady) begin
            if (storeExpect.size() == 0) begin
                noteError($sformatf("Store tag 0x%02h announced but none was issued", storeTag));
            end else begin
                st = storeExpect.pop_front();
                checkValue("storeTag", 32'(storeTag), 32'(st[5:0]));
                storeWaiting = 1'b1;
                storeHeld    = st[6];
                fireGap      = $unsigned($random(seed)) % 4;
            end
        end
        if (storeWaiting && !storeHeld) begin
            if (fireGap == 0) begin
                fireStore    = 1'b1;
                storeWaiting = 1'b0;
            end else begin
                fireGap--;
            end
        end
    endtask

    task automatic issueUop(input int base, input logic held, input logic dropped);
        int         gap;
        int         waited;
        logic [3:0] op;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) advanceCycle();
        op             = vecMem[base+1][3:0];
        issueOp        = LsuOp'(op);
        issueBase      = vecMem[base+2];
        issueImm       = vecMem[base+3][15:0];
        issueStoreData = vecMem[base+4];
        issueDst       = vecMem[base+5][5:0];
        issueTag       = vecMem[base+6][5:0];
        issueValid     = 1'b1;
        waited = 0;
        while (!issueReady && waited < TIMEOUT_CYCLES) begin
            advanceCycle();
            waited++;
        end
        if (!issueReady) begin
            issueValid = 1'b0;
            reportTimeout($sformatf("issueReady stayed low for uop tag 0x%02h", issueTag));
        end else begin
            if (op >= 4'h1 && op <= 4'h5 && !dropped) begin
                wbExpect.push_back({issueDst, issueTag, vecMem[base+7]});
            end else if (op >= 4'h6 && op <= 4'h8) begin
                storeExpect.push_back({held, issueTag});
            end
            advanceCycle();
            issueValid = 1'b0;
        end
    endtask

    task automatic waitHeldStore();
        int waited;
        waited = 0;
        while (!(storeWaiting && storeHeld) && waited < TIMEOUT_CYCLES) begin
            advanceCycle();
            waited++;
        end
        if (!(storeWaiting && storeHeld)) begin
            reportTimeout("the held store was never announced on storeReady");
        end
    endtask

    task automatic fireHeldStore(input logic expectReady);
        int gap;
        waitHeldStore();
        if (!abortRun) begin
            gap = 4 + $unsigned($random(seed)) % 4;
            repeat (gap) advanceCycle();
            checkValue("issueReady", 32'(issueReady), 32'(expectReady));
            fireStore    = 1'b1;
            storeWaiting = 1'b0;
            storeHeld    = 1'b0;
        end
    endtask

    task automatic flushHeldStore();
        waitHeldStore();
        if (!abortRun) begin
            flush = 1'b1;
            advanceCycle();
            storeWaiting = 1'b0;
            storeHeld    = 1'b0;
            checkValue("busy", 32'(busy), 32'h0);
            checkValue("issueReady", 32'(issueReady), 32'h1);
        end
    endtask

    task automatic finishTest(input int testId);
        int waited;
        waited = 0;
        while (!allDrained() && waited < TIMEOUT_CYCLES) begin
            advanceCycle();
            waited++;
        end
        if (!allDrained()) begin
            reportTimeout("outstanding uops never completed");
        end
        $display("Test %0d finished with %0d errors", testId, testErrors);
        testCount++;
        testErrors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int         line;
        int         base;
        logic [3:0] kind;
        rst            = 1'b1;
        flush          = 1'b0;
        fireStore      = 1'b0;
        issueValid     = 1'b0;
        issueOp        = OpNop;
        issueBase      = '0;
        issueImm       = '0;
        issueStoreData = '0;
        issueDst       = '0;
        issueTag       = '0;
        storeWaiting   = 1'b0;
        storeHeld      = 1'b0;
        abortRun       = 1'b0;
        fireGap        = 0;
        errorCount     = 0;
        testErrors     = 0;
        testCount      = 0;
        checkCount     = 0;
        for (int i = 0; i < MAX_VECTORS*VEC_FIELDS; i++) begin
            vecMem[i] = '0;
        end
        $readmemh("lsuTests.mem", vecMem);

        repeat (4) @(posedge clk);
        @(negedge clk);
        checkValue("issueReady", 32'(issueReady), 32'h0);
        checkValue("busy", 32'(busy), 32'h0);
        checkValue("wbValid", 32'(wbValid), 32'h0);
        checkValue("storeReady", 32'(storeReady), 32'h0);
        rst = 1'b0;

        line = 0;
        kind = vecMem[0][3:0];
        while (kind != KIND_END && !abortRun && line < MAX_VECTORS) begin
            base = line * VEC_FIELDS;
            case (kind)
                KIND_ISSUE: issueUop(base, 1'b0, 1'b0);
                KIND_HOLD:  issueUop(base, 1'b1, 1'b0);
                KIND_DROP:  issueUop(base, 1'b0, 1'b1);
                KIND_FIRE:  fireHeldStore(vecMem[base+7][0]);
                KIND_FLUSH: flushHeldStore();
                KIND_DONE:  finishTest(int'(vecMem[base+7]));
                default:    noteError($sformatf("Test file line %0d has unknown kind %0h",
                                                line, kind));
            endcase
            line++;
            if (line < MAX_VECTORS) begin
                kind = vecMem[line*VEC_FIELDS][3:0];
            end
        end
        if (testCount == 0) begin
            noteError("No tests were read from the test file");
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uopQueue.sv
`timescale 1ns/1ps
`default_nettype none

module uopQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     issueValid,
    output logic                    issueReady,
    input  wire lsuOpsPkg::LsuOp    issueOp,
    input  wire lsuOpsPkg::Word     issueBase,
    input  wire lsuOpsPkg::Imm16    issueImm,
    input  wire lsuOpsPkg::Word     issueStoreData,
    input  wire lsuOpsPkg::PhysReg  issueDst,
    input  wire lsuOpsPkg::RobTag   issueTag,
    input  wire                     pop,
    output logic                    headValid,
    output lsuOpsPkg::LsuOp         headOp,
    output lsuOpsPkg::Word          headBase,
    output lsuOpsPkg::Imm16         headImm,
    output lsuOpsPkg::Word          headStoreData,
    output lsuOpsPkg::PhysReg       headDst,
    output lsuOpsPkg::RobTag        headTag
);
    import lsuOpsPkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Uop storage, one array per field
    LsuOp   opMem   [QUEUE_DEPTH];
    Word    baseMem [QUEUE_DEPTH];
    Imm16   immMem  [QUEUE_DEPTH];
    Word    dataMem [QUEUE_DEPTH];
    PhysReg dstMem  [QUEUE_DEPTH];
    RobTag  tagMem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] countNext;
    logic             push;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = issueValid && issueReady;

    always_comb begin
        case ({push, pop})
            2'b10:   countNext = count + 1'b1;
            2'b01:   countNext = count - 1'b1;
            default: countNext = count;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pointers, occupancy and registered full flag
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            issueReady <= 1'b0;
        end else if (flush) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            issueReady <= 1'b1;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count      <= countNext;
            issueReady <= (countNext != CNT_W'(QUEUE_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[wrPtr]   <= issueOp;
            baseMem[wrPtr] <= issueBase;
            immMem[wrPtr]  <= issueImm;
            dataMem[wrPtr] <= issueStoreData;
            dstMem[wrPtr]  <= issueDst;
            tagMem[wrPtr]  <= issueTag;
        end
    end

    // Head is read straight from storage
    assign headValid     = (count != '0);
    assign headOp        = opMem[rdPtr];
    assign headBase      = baseMem[rdPtr];
    assign headImm       = immMem[rdPtr];
    assign headStoreData = dataMem[rdPtr];
    assign headDst       = dstMem[rdPtr];
    assign headTag       = tagMem[rdPtr];

    // The unit may only take a uop that is actually there
    popNeedsHead : assert property (@(posedge clk) disable iff (rst)
        pop |-> headValid);

endmodule

`default_nettype wire
